/* source/lane_mask_pkg.sv */
/*
 * Lane mask shared definitions
 * Pixel and gray widths plus the state encoding of the capture FSM
 */
`default_nettype none

package lane_mask_pkg;

    // One RGB pixel, red in the top byte and blue in the bottom byte
    localparam int pixel_bits = 24;

    // One gray value of the mask
    localparam int gray_bits = 8;

    // States of the mask capture FSM
    typedef enum logic [1:0] {
        // Waiting for the first pixel of a frame
        CAPTURE_IDLE,
        // Converting pixels and writing those inside the region
        CAPTURE_ACTIVE,
        // Region complete, the rest of the frame is read and dropped
        CAPTURE_DRAIN,
        // Frame fully read, waiting for the streamer to release the mask
        CAPTURE_HOLD
    } capture_state_t;

endpackage

`default_nettype wire

/* source/pixel_fifo.sv */
/*
 * Pixel FIFO
 * First-word-fall-through buffer between the camera side and the capture FSM
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
    parameter int fifo_depth = 4
) (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              in_valid,
    input  wire logic [lane_mask_pkg::pixel_bits-1:0] in_pixel,
    output logic                                   in_ready,
    input  wire logic                              fifo_pop,
    output logic                                   fifo_empty,
    output logic [lane_mask_pkg::pixel_bits-1:0]   fifo_pixel
);

    import lane_mask_pkg::*;

    // A depth of one still needs a one bit pointer
    localparam int ptr_bits = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int count_bits = $clog2(fifo_depth + 1);
    localparam logic [ptr_bits-1:0] last_ptr = ptr_bits'(fifo_depth - 1);
    localparam logic [count_bits-1:0] full_count = count_bits'(fifo_depth);

    logic [pixel_bits-1:0] buffer [fifo_depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [count_bits-1:0] count;
    logic do_write;
    logic do_pop;

    // Full means no room for another pixel this cycle
    assign in_ready = (count != full_count);
    assign fifo_empty = (count == '0);

    // The head entry is visible without any read delay
    assign fifo_pixel = buffer[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_pop = fifo_pop && !fifo_empty;

    // Storage array, written only on an accepted transfer
    always_ff @(posedge clock) begin
        if (do_write) begin
            buffer[wr_ptr] <= in_pixel;
        end
    end

    // Pointers wrap at the depth, so any depth works and not only powers of two
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            // A write and a pop together leave the count unchanged
            if (do_write && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/grayscale_mask.sv */
/*
 * Grayscale mask capture
 * Converts each pixel to the average of its channels and writes only the
 * pixels inside the region of interest to the mask memory
 */
`timescale 1ns/1ps
`default_nettype none

module grayscale_mask #(
    parameter int image_width  = 8,
    parameter int image_height = 6,
    parameter int roi_x        = 2,
    parameter int roi_y        = 1,
    parameter int roi_width    = 4,
    parameter int roi_height   = 3
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic                                 fifo_empty,
    input  wire logic [lane_mask_pkg::pixel_bits-1:0] fifo_pixel,
    output logic                                      fifo_pop,
    output logic                                      mask_wr_en,
    output logic [$clog2(roi_width*roi_height)-1:0]   mask_wr_addr,
    output logic [lane_mask_pkg::gray_bits-1:0]       mask_wr_data,
    output logic                                      mask_full,
    input  wire logic                                 hough_done
);

    import lane_mask_pkg::*;

    localparam int addr_bits = $clog2(roi_width * roi_height);
    localparam int col_bits = (image_width > 1) ? $clog2(image_width) : 1;
    localparam int row_bits = (image_height > 1) ? $clog2(image_height) : 1;
    localparam int roi_col_bits = (roi_width > 1) ? $clog2(roi_width) : 1;
    localparam int roi_row_bits = (roi_height > 1) ? $clog2(roi_height) : 1;
    localparam int roi_x_end = roi_x + roi_width - 1;
    localparam int roi_y_end = roi_y + roi_height - 1;

    capture_state_t state, state_next;
    logic [col_bits-1:0] img_col, img_col_next;
    logic [row_bits-1:0] img_row, img_row_next;
    logic [roi_col_bits-1:0] roi_col, roi_col_next;
    logic [roi_row_bits-1:0] roi_row, roi_row_next;
    logic release_seen, release_seen_next;
    logic [gray_bits+1:0] channel_sum;
    logic in_roi;
    logic roi_last;
    logic frame_last;

    // Sum of the three channels needs two extra bits before the divide
    assign channel_sum = {2'b00, fifo_pixel[23:16]} + {2'b00, fifo_pixel[15:8]}
                       + {2'b00, fifo_pixel[7:0]};

    assign in_roi = (int'(img_col) >= roi_x) && (int'(img_col) <= roi_x_end)
                 && (int'(img_row) >= roi_y) && (int'(img_row) <= roi_y_end);
    assign roi_last = (int'(roi_col) == roi_width - 1) && (int'(roi_row) == roi_height - 1);
    assign frame_last = (int'(img_col) == image_width - 1)
                     && (int'(img_row) == image_height - 1);

    // The streamer may read the memory once the region is complete
    assign mask_full = (state == CAPTURE_DRAIN) || (state == CAPTURE_HOLD);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= CAPTURE_IDLE;
            img_col <= '0;
            img_row <= '0;
            roi_col <= '0;
            roi_row <= '0;
            release_seen <= 1'b0;
        end else begin
            state <= state_next;
            img_col <= img_col_next;
            img_row <= img_row_next;
            roi_col <= roi_col_next;
            roi_row <= roi_row_next;
            release_seen <= release_seen_next;
        end
    end

    always_comb begin
        state_next = state;
        img_col_next = img_col;
        img_row_next = img_row;
        roi_col_next = roi_col;
        roi_row_next = roi_row;
        release_seen_next = release_seen;
        fifo_pop = 1'b0;
        mask_wr_en = 1'b0;
        mask_wr_addr = '0;
        mask_wr_data = '0;

        case (state)
            CAPTURE_IDLE: begin
                // A waiting pixel opens a new frame with all coordinates at zero
                if (!fifo_empty) begin
                    state_next = CAPTURE_ACTIVE;
                    img_col_next = '0;
                    img_row_next = '0;
                    roi_col_next = '0;
                    roi_row_next = '0;
                    release_seen_next = 1'b0;
                end
            end

            CAPTURE_ACTIVE, CAPTURE_DRAIN: begin
                if (!fifo_empty) begin
                    fifo_pop = 1'b1;
                    // Only the active state writes, and only inside the region
                    if (state == CAPTURE_ACTIVE && in_roi) begin
                        mask_wr_en = 1'b1;
                        mask_wr_addr = addr_bits'(roi_row) * addr_bits'(roi_width)
                                     + addr_bits'(roi_col);
                        mask_wr_data = gray_bits'(channel_sum / 3);
                        if (roi_last) begin
                            state_next = CAPTURE_DRAIN;
                        end else if (int'(roi_col) == roi_width - 1) begin
                            roi_col_next = '0;
                            roi_row_next = roi_row + 1'b1;
                        end else begin
                            roi_col_next = roi_col + 1'b1;
                        end
                    end
                    // Image coordinates advance on every pixel read
                    if (frame_last) begin
                        // A frame that ends short of the region is dropped
                        if (state == CAPTURE_DRAIN || (in_roi && roi_last)) begin
                            state_next = CAPTURE_HOLD;
                        end else begin
                            state_next = CAPTURE_IDLE;
                        end
                    end else if (int'(img_col) == image_width - 1) begin
                        img_col_next = '0;
                        img_row_next = img_row + 1'b1;
                    end else begin
                        img_col_next = img_col + 1'b1;
                    end
                end
                // The streamer can finish before the frame tail is drained
                if (state == CAPTURE_DRAIN && hough_done) begin
                    release_seen_next = 1'b1;
                end
            end

            CAPTURE_HOLD: begin
                // The memory stays untouched until the mask has been streamed
                if (hough_done || release_seen) begin
                    state_next = CAPTURE_IDLE;
                    release_seen_next = 1'b0;
                end
            end

            default: begin
                state_next = CAPTURE_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/mask_bram.sv */
/*
 * Mask memory
 * Simple dual-port block RAM holding one gray value per region pixel
 */
`timescale 1ns/1ps
`default_nettype none

module mask_bram #(
    parameter int depth = 12
) (
    input  wire logic                               clock,
    input  wire logic                               mask_wr_en,
    input  wire logic [$clog2(depth)-1:0]           mask_wr_addr,
    input  wire logic [lane_mask_pkg::gray_bits-1:0] mask_wr_data,
    input  wire logic                               mask_rd_en,
    input  wire logic [$clog2(depth)-1:0]           mask_rd_addr,
    output logic [lane_mask_pkg::gray_bits-1:0]     mask_rd_data
);

    import lane_mask_pkg::*;

    logic [gray_bits-1:0] mem [depth];

    // Write port
    always_ff @(posedge clock) begin
        if (mask_wr_en) begin
            mem[mask_wr_addr] <= mask_wr_data;
        end
    end

    // Read data appears one cycle after the enable and then holds
    always_ff @(posedge clock) begin
        if (mask_rd_en) begin
            mask_rd_data <= mem[mask_rd_addr];
        end
    end

endmodule

`default_nettype wire

/* source/mask_streamer.sv */
/*
 * Mask streamer
 * Reads the completed mask in address order and sends it out with
 * valid/ready, then pulses completion to release the capture block
 */
`timescale 1ns/1ps
`default_nettype none

module mask_streamer #(
    parameter int roi_width  = 4,
    parameter int roi_height = 3
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic                                 mask_full,
    output logic                                      mask_rd_en,
    output logic [$clog2(roi_width*roi_height)-1:0]   mask_rd_addr,
    input  wire logic [lane_mask_pkg::gray_bits-1:0]  mask_rd_data,
    output logic                                      out_valid,
    input  wire logic                                 out_ready,
    output logic [lane_mask_pkg::gray_bits-1:0]       out_gray,
    output logic                                      out_last,
    output logic                                      hough_done
);

    localparam int addr_bits = $clog2(roi_width * roi_height);
    localparam logic [addr_bits-1:0] last_addr = addr_bits'(roi_width * roi_height - 1);

    logic active;
    logic armed;
    logic all_read;
    logic rd_pending;
    logic last_pending;
    logic accept;

    assign accept = out_valid && out_ready;

    // A new read waits until the output register is free or being emptied
    assign mask_rd_en = active && !all_read && !rd_pending && (!out_valid || out_ready);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
            armed <= 1'b1;
            all_read <= 1'b0;
            rd_pending <= 1'b0;
            last_pending <= 1'b0;
            mask_rd_addr <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
            hough_done <= 1'b0;
        end else begin
            hough_done <= 1'b0;
            rd_pending <= mask_rd_en;
            last_pending <= mask_rd_en && (mask_rd_addr == last_addr);

            // The same mask is never sent twice, so wait for it to be released
            if (!mask_full) begin
                armed <= 1'b1;
            end

            if (!active && mask_full && armed) begin
                active <= 1'b1;
                all_read <= 1'b0;
                mask_rd_addr <= '0;
            end else if (mask_rd_en) begin
                if (mask_rd_addr == last_addr) begin
                    all_read <= 1'b1;
                end else begin
                    mask_rd_addr <= mask_rd_addr + 1'b1;
                end
            end

            // Read data lands in the output register, which is always free here
            if (rd_pending) begin
                out_valid <= 1'b1;
                out_last <= last_pending;
            end else if (accept) begin
                out_valid <= 1'b0;
                out_last <= 1'b0;
                if (out_last) begin
                    active <= 1'b0;
                    armed <= 1'b0;
                    hough_done <= 1'b1;
                end
            end
        end
    end

    // Beat payload, loaded with the read data and held until accepted
    always_ff @(posedge clock) begin
        if (rd_pending) begin
            out_gray <= mask_rd_data;
        end
    end

endmodule

`default_nettype wire

/* source/mask_capture_top.sv */
/*
 * Mask capture top level
 * Pixel FIFO, grayscale capture FSM, mask memory and mask streamer
 */
`timescale 1ns/1ps
`default_nettype none

module mask_capture_top #(
    parameter int image_width  = 64,
    parameter int image_height = 48,
    parameter int roi_x        = 16,
    parameter int roi_y        = 24,
    parameter int roi_width    = 32,
    parameter int roi_height   = 16,
    parameter int fifo_depth   = 8
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic                                 in_valid,
    output logic                                      in_ready,
    input  wire logic [lane_mask_pkg::pixel_bits-1:0] in_pixel,
    output logic                                      out_valid,
    input  wire logic                                 out_ready,
    output logic [lane_mask_pkg::gray_bits-1:0]       out_gray,
    output logic                                      out_last
);

    import lane_mask_pkg::*;

    localparam int mask_depth = roi_width * roi_height;
    localparam int addr_bits = $clog2(mask_depth);

    // FIFO read side
    logic fifo_empty;
    logic fifo_pop;
    logic [pixel_bits-1:0] fifo_pixel;

    // Mask memory ports
    logic mask_wr_en;
    logic [addr_bits-1:0] mask_wr_addr;
    logic [gray_bits-1:0] mask_wr_data;
    logic mask_rd_en;
    logic [addr_bits-1:0] mask_rd_addr;
    logic [gray_bits-1:0] mask_rd_data;

    // Handshake between capture and streamer
    logic mask_full;
    logic hough_done;

    pixel_fifo #(
        .fifo_depth (fifo_depth)
    ) u_pixel_fifo (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_pixel   (in_pixel),
        .in_ready   (in_ready),
        .fifo_pop   (fifo_pop),
        .fifo_empty (fifo_empty),
        .fifo_pixel (fifo_pixel)
    );

    grayscale_mask #(
        .image_width  (image_width),
        .image_height (image_height),
        .roi_x        (roi_x),
        .roi_y        (roi_y),
        .roi_width    (roi_width),
        .roi_height   (roi_height)
    ) u_grayscale_mask (
        .clock        (clock),
        .reset        (reset),
        .fifo_empty   (fifo_empty),
        .fifo_pixel   (fifo_pixel),
        .fifo_pop     (fifo_pop),
        .mask_wr_en   (mask_wr_en),
        .mask_wr_addr (mask_wr_addr),
        .mask_wr_data (mask_wr_data),
        .mask_full    (mask_full),
        .hough_done   (hough_done)
    );

    mask_bram #(
        .depth (mask_depth)
    ) u_mask_bram (
        .clock        (clock),
        .mask_wr_en   (mask_wr_en),
        .mask_wr_addr (mask_wr_addr),
        .mask_wr_data (mask_wr_data),
        .mask_rd_en   (mask_rd_en),
        .mask_rd_addr (mask_rd_addr),
        .mask_rd_data (mask_rd_data)
    );

    mask_streamer #(
        .roi_width  (roi_width),
        .roi_height (roi_height)
    ) u_mask_streamer (
        .clock        (clock),
        .reset        (reset),
        .mask_full    (mask_full),
        .mask_rd_en   (mask_rd_en),
        .mask_rd_addr (mask_rd_addr),
        .mask_rd_data (mask_rd_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_gray     (out_gray),
        .out_last     (out_last),
        .hough_done   (hough_done)
    );

endmodule

`default_nettype wire

/* verif/mask_capture_sva.sv */
/*
 * Mask capture handshake assertions
 * Bound to the top level to watch the output stream and the reset values
 */
`timescale 1ns/1ps
`default_nettype none

module mask_capture_sva (
    input wire logic                                clock,
    input wire logic                                reset,
    input wire logic                                in_ready,
    input wire logic                                out_valid,
    input wire logic                                out_ready,
    input wire logic [lane_mask_pkg::gray_bits-1:0] out_gray,
    input wire logic                                out_last
);

    // A stalled beat keeps its payload until it is accepted
    stall_holds_beat: assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_gray) && $stable(out_last)))
        else $error("Output beat changed while out_ready was low");

    last_needs_valid: assert property (@(posedge clock) disable iff (reset)
        out_last |-> out_valid)
        else $error("out_last high without out_valid");

    // Reset leaves the FIFO empty and the streamer idle
    reset_values: assert property (@(posedge clock)
        reset |-> (in_ready && !out_valid))
        else $error("in_ready or out_valid wrong while reset is high");

endmodule

bind mask_capture_top mask_capture_sva sva_i (
    .clock     (clock),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_gray  (out_gray),
    .out_last  (out_last)
);

`default_nettype wire

/* verif/mask_capture_tb.sv */
/*
 * Mask capture testbench
 * Sends a table of frames through the capture pipeline and compares every
 * streamed mask beat with a reference model of the region gray average
 */
`timescale 1ns/1ps
`default_nettype none

module mask_capture_tb;

    import lane_mask_pkg::*;

    localparam int image_width = 8;
    localparam int image_height = 6;
    localparam int roi_x = 2;
    localparam int roi_y = 1;
    localparam int roi_width = 4;
    localparam int roi_height = 3;
    localparam int fifo_depth = 4;
    localparam int frame_size = image_width * image_height;
    localparam int mask_size = roi_width * roi_height;
    localparam int num_frames = 7;
    localparam int beat_timeout = 1000;
    localparam int input_timeout = 2000;

    // Pixel pattern kinds
    localparam int pattern_corner = 0;
    localparam int pattern_zero = 1;
    localparam int pattern_full = 2;
    localparam int pattern_random = 3;

    // Duty modes of out_ready
    localparam int ready_always = 0;
    localparam int ready_random = 1;
    localparam int ready_long_low = 2;

    typedef struct packed {
        int pattern;
        int ready_mode;
        bit back_to_back;
    } frame_row_t;

    // One row per frame, applied in order
    localparam frame_row_t frame_table [num_frames] = '{
        '{pattern_corner, ready_always, 1'b0},
        '{pattern_zero, ready_always, 1'b1},
        '{pattern_full, ready_random, 1'b1},
        '{pattern_random, ready_long_low, 1'b0},
        '{pattern_random, ready_long_low, 1'b1},
        '{pattern_random, ready_random, 1'b1},
        '{pattern_random, ready_always, 1'b1}
    };

    logic clock;
    logic reset;
    logic in_valid;
    logic in_ready;
    logic [pixel_bits-1:0] in_pixel;
    logic out_valid;
    logic out_ready;
    logic [gray_bits-1:0] out_gray;
    logic out_last;

    logic [pixel_bits-1:0] frame_pixels [num_frames][frame_size];
    logic [gray_bits-1:0] expected_mask [num_frames][mask_size];
    int frames_received;
    int low_run;
    bit in_ready_low_seen;

    mask_capture_top #(
        .image_width  (image_width),
        .image_height (image_height),
        .roi_x        (roi_x),
        .roi_y        (roi_y),
        .roi_width    (roi_width),
        .roi_height   (roi_height),
        .fifo_depth   (fifo_depth)
    ) dut_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pixel  (in_pixel),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_gray  (out_gray),
        .out_last  (out_last)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Equal weight average of the three channels, rounded down
    function automatic logic [gray_bits-1:0] gray_of(input logic [pixel_bits-1:0] px);
        int sum;
        sum = int'(px[23:16]) + int'(px[15:8]) + int'(px[7:0]);
        return gray_bits'(sum / 3);
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_value(input string signal_name, input int expected,
                                 input int actual);
        assert (expected == actual) else begin
            $display("Mismatch at time %0t: %s expected %0d, got %0d",
                     $time, signal_name, expected, actual);
            abort_run();
        end
    endtask

    // Fills one frame and derives its mask from the region rule
    task automatic build_frame(input int f);
        int k;
        for (int p = 0; p < frame_size; p++) begin
            case (frame_table[f].pattern)
                pattern_zero: frame_pixels[f][p] = 24'h000000;
                pattern_full: frame_pixels[f][p] = 24'hffffff;
                pattern_random: frame_pixels[f][p] = pixel_bits'($urandom());
                default: frame_pixels[f][p] = {8'(p * 5), 8'(p * 3 + 7), 8'(255 - p)};
            endcase
        end
        if (frame_table[f].pattern == pattern_corner) begin
            // Region corners should come out as 0, 255, 2 and 85
            frame_pixels[f][roi_y * image_width + roi_x] = 24'h000000;
            frame_pixels[f][roi_y * image_width + roi_x + roi_width - 1] = 24'hffffff;
            frame_pixels[f][(roi_y + roi_height - 1) * image_width + roi_x] = 24'h010203;
            frame_pixels[f][(roi_y + roi_height - 1) * image_width + roi_x + roi_width - 1]
                = 24'hff0000;
        end
        k = 0;
        for (int y = 0; y < image_height; y++) begin
            for (int x = 0; x < image_width; x++) begin
                if (x >= roi_x && x < roi_x + roi_width
                        && y >= roi_y && y < roi_y + roi_height) begin
                    expected_mask[f][k] = gray_of(frame_pixels[f][y * image_width + x]);
                    k++;
                end
            end
        end
    endtask

    // Long lows come in runs of 9 to 24 cycles
    task automatic drive_out_ready(input int mode);
        case (mode)
            ready_random: out_ready = ($urandom() % 2) == 0;
            ready_long_low: begin
                if (low_run > 0) begin
                    out_ready = 1'b0;
                    low_run = low_run - 1;
                end else if (($urandom() % 4) == 0) begin
                    out_ready = 1'b0;
                    low_run = 8 + int'($urandom() % 16);
                end else begin
                    out_ready = 1'b1;
                end
            end
            default: out_ready = 1'b1;
        endcase
    endtask

    task automatic send_frames();
        int stall_cycles;
        bit accepted;
        for (int f = 0; f < num_frames; f++) begin
            // A frame with a gap starts only once the previous mask is out
            if (!frame_table[f].back_to_back) begin
                stall_cycles = 0;
                while (frames_received < f) begin
                    @(posedge clock);
                    stall_cycles++;
                    assert (stall_cycles < input_timeout) else begin
                        $display("Timeout: mask of frame %0d never finished", f - 1);
                        abort_run();
                    end
                end
            end
            for (int p = 0; p < frame_size; p++) begin
                @(negedge clock);
                in_valid = 1'b1;
                in_pixel = frame_pixels[f][p];
                accepted = 1'b0;
                stall_cycles = 0;
                while (!accepted) begin
                    @(posedge clock);
                    if (in_ready) begin
                        accepted = 1'b1;
                    end else begin
                        in_ready_low_seen = 1'b1;
                        stall_cycles++;
                        assert (stall_cycles < input_timeout) else begin
                            $display("Timeout: pixel %0d of frame %0d never accepted", p, f);
                            abort_run();
                        end
                    end
                end
            end
            if (f == num_frames - 1 || !frame_table[f + 1].back_to_back) begin
                @(negedge clock);
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic receive_masks();
        int beat;
        int idle_cycles;
        for (int f = 0; f < num_frames; f++) begin
            beat = 0;
            idle_cycles = 0;
            while (beat < mask_size) begin
                @(negedge clock);
                drive_out_ready(frame_table[f].ready_mode);
                @(posedge clock);
                if (out_valid && out_ready) begin
                    compare_value("out_gray", int'(expected_mask[f][beat]), int'(out_gray));
                    compare_value("out_last", int'(beat == mask_size - 1), int'(out_last));
                    beat++;
                    idle_cycles = 0;
                end else begin
                    idle_cycles++;
                    assert (idle_cycles < beat_timeout) else begin
                        $display("Timeout: beat %0d of frame %0d never arrived", beat, f);
                        abort_run();
                    end
                end
            end
            frames_received = f + 1;
        end
    endtask

    initial begin
        void'($urandom(52914));
        reset = 1'b1;
        in_valid = 1'b0;
        in_pixel = '0;
        out_ready = 1'b0;
        frames_received = 0;
        low_run = 0;
        in_ready_low_seen = 1'b0;
        for (int f = 0; f < num_frames; f++) begin
            build_frame(f);
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // Idle state right after reset, before any pixel
        @(negedge clock);
        compare_value("in_ready", 1, int'(in_ready));
        compare_value("out_valid", 0, int'(out_valid));
        fork
            send_frames();
            receive_masks();
        join
        // Nothing may follow the last mask
        @(negedge clock);
        out_ready = 1'b1;
        repeat (40) begin
            @(posedge clock);
            compare_value("out_valid", 0, int'(out_valid));
        end
        assert (in_ready_low_seen) else begin
            $display("The input side never stalled while a mask was held back");
            abort_run();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* mask_capture_top.f */
source/lane_mask_pkg.sv
source/pixel_fifo.sv
source/grayscale_mask.sv
source/mask_bram.sv
source/mask_streamer.sv
source/mask_capture_top.sv
verif/mask_capture_sva.sv
verif/mask_capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mask capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --assert \
    --top-module mask_capture_tb \
    --Mdir "$build_dir" -o mask_capture_sim \
    -f mask_capture_top.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/mask_capture_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"

if grep -q "TESTS FAILED" "$log_file"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "TESTS PASSED" "$log_file"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
